// File: src.f
common/audio_pkg.sv
hw/key_command_decoder.sv
hw/sample_rate_gen.sv
playback/song_address_counter.sv
playback/flash_read_sequencer.sv
playback/sample_byte_latch.sv
hw/audio_player_top.sv
verif/tb_flash_model.sv
verif/tb_audio_player.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_audio_player -f src.f -o tb_audio_player &&
./obj_dir/tb_audio_player || exit 1

// File: verif/tb_audio_player.sv
`timescale 1ns/1ps

module tb_audio_player;

  import audio_pkg::*;

  localparam flash_addr_t last_word       = 23'd7;
  localparam sample_t     code_speed_up   = 8'h2B;
  localparam sample_t     code_speed_down = 8'h2D;
  localparam sample_t     code_reset      = 8'h21;
  localparam int          n_rows          = 17;

  // Key or event, then samples to collect, idle periods or speed pulses
  typedef struct packed {
    sample_t    code;
    logic [7:0] count;
    period_t    period;
  } row_t;

  row_t stim [n_rows] = '{
    '{cmd_play,        8'd6,  16'd60},
    '{8'h58,           8'd2,  16'd60},
    '{cmd_play,        8'd10, 16'd60},
    '{cmd_pause,       8'd3,  16'd60},
    '{cmd_play,        8'd4,  16'd60},
    '{cmd_backward,    8'd10, 16'd60},
    '{cmd_restart,     8'd4,  16'd60},
    '{cmd_forward,     8'd2,  16'd60},
    '{cmd_restart,     8'd4,  16'd60},
    '{cmd_pause,       8'd3,  16'd60},
    '{code_speed_up,   8'd5,  16'd55},
    '{code_speed_down, 8'd2,  16'd57},
    '{code_speed_up,   8'd25, 16'd40},
    '{cmd_play,        8'd4,  16'd40},
    '{cmd_backward,    8'd2,  16'd40},
    '{code_reset,      8'd3,  16'd60},
    '{cmd_play,        8'd4,  16'd60}
  };

  logic        CLK_50M = 1'b0;
  logic        speed_reset_event;
  sample_t     key_ascii;
  logic        key_valid;
  logic        speed_up_event;
  logic        speed_down_event;
  logic        flash_waitrequest;
  flash_data_t flash_readdata;
  logic        flash_readdatavalid;
  logic        flash_read;
  flash_addr_t flash_address;
  sample_t     sample_out;
  logic        sample_valid;
  period_t     sample_period;

  // Reference model of the play position
  flash_addr_t model_addr;
  logic        model_second;
  logic        model_forward;
  int          sample_count;
  logic        outstanding;

  always #10 CLK_50M = ~CLK_50M;

  audio_player_top #(
    .default_period (16'd60),
    .min_period     (16'd40),
    .last_word_addr (last_word)
  ) dut0 (
    .CLK_50M             (CLK_50M),
    .speed_reset_event   (speed_reset_event),
    .key_ascii           (key_ascii),
    .key_valid           (key_valid),
    .speed_up_event      (speed_up_event),
    .speed_down_event    (speed_down_event),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .sample_out          (sample_out),
    .sample_valid        (sample_valid),
    .sample_period       (sample_period)
  );

  tb_flash_model flash0 (
    .CLK_50M             (CLK_50M),
    .speed_reset_event   (speed_reset_event),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_sample(input sample_t got, input sample_t exp);
    if (got !== exp)
      report_failure($sformatf("Fail at %0t: sample %0d is %h, expected %h",
                               $time, sample_count, got, exp));
  endtask

  task automatic check_period(input period_t got, input period_t exp);
    if (got !== exp)
      report_failure($sformatf("Fail at %0t: sample_period is %0d, expected %0d",
                               $time, got, exp));
  endtask

  task automatic check_address(input flash_addr_t got, input flash_addr_t exp);
    if (got !== exp)
      report_failure($sformatf("Fail at %0t: flash read at address %0d, expected %0d",
                               $time, got, exp));
  endtask

  // Reads never overlap and each one fetches the word the model expects
  always @(posedge CLK_50M)
  begin
    if (speed_reset_event)
      outstanding <= 1'b0;
    else if (flash_read && outstanding)
      report_failure($sformatf("A flash read started at %0t while another was outstanding",
                               $time));
    else if (flash_read && !flash_waitrequest)
    begin
      check_address(flash_address, model_addr);
      outstanding <= 1'b1;
    end
    else if (flash_readdatavalid)
      outstanding <= 1'b0;
  end

  // Forward takes the high byte first, backward the low byte
  function automatic sample_t expected_sample();
    sample_t hi;
    sample_t lo;
    hi = sample_t'(int'(model_addr) * 16 + 1);
    lo = sample_t'(int'(model_addr) * 16 + 2);
    if (model_forward)
      return model_second ? lo : hi;
    else
      return model_second ? hi : lo;
  endfunction

  task automatic collect_samples(input int n, input period_t period);
    int k;
    int waited;
    for (k = 0; k < n; k++)
    begin
      waited = 0;
      @(posedge CLK_50M);
      while (!sample_valid && (waited < 8 * int'(period)))
      begin
        @(posedge CLK_50M);
        waited++;
      end
      if (!sample_valid)
        report_failure($sformatf("Timed out at %0t waiting for sample %0d",
                                 $time, sample_count));
      check_sample(sample_out, expected_sample());
      sample_count++;
      // Word done after its second sample
      if (model_second)
      begin
        if (model_forward)
          model_addr = (model_addr == last_word) ? '0 : model_addr + 23'd1;
        else
          model_addr = (model_addr == '0) ? last_word : model_addr - 23'd1;
      end
      model_second = !model_second;
    end
  endtask

  task automatic watch_silence(input int periods, input period_t period);
    int k;
    for (k = 0; k < periods * int'(period); k++)
    begin
      @(posedge CLK_50M);
      if (sample_valid)
        report_failure($sformatf("Fail at %0t: sample_valid high while stopped", $time));
    end
  endtask

  task automatic apply_row(input row_t r);
    int k;
    case (r.code)
      code_speed_up, code_speed_down:
        for (k = 0; k < int'(r.count); k++)
        begin
          @(posedge CLK_50M);
          speed_up_event   <= (r.code == code_speed_up);
          speed_down_event <= (r.code == code_speed_down);
          @(posedge CLK_50M);
          speed_up_event   <= 1'b0;
          speed_down_event <= 1'b0;
        end
      code_reset:
      begin
        @(posedge CLK_50M);
        speed_reset_event <= 1'b1;
        repeat (5) @(posedge CLK_50M);
        speed_reset_event <= 1'b0;
        model_addr    = '0;
        model_second  = 1'b0;
        model_forward = 1'b1;
        watch_silence(int'(r.count), r.period);
      end
      default:
      begin
        @(posedge CLK_50M);
        key_ascii <= r.code;
        key_valid <= 1'b1;
        @(posedge CLK_50M);
        key_valid <= 1'b0;
        if (r.code == cmd_forward)
          model_forward = 1'b1;
        if (r.code == cmd_backward)
          model_forward = 1'b0;
        if (r.code == cmd_restart)
        begin
          model_addr   = model_forward ? '0 : last_word;
          model_second = 1'b0;
        end
        if (r.code == cmd_pause)
          watch_silence(int'(r.count), r.period);
        else
          collect_samples(int'(r.count), r.period);
      end
    endcase
    @(posedge CLK_50M);
    check_period(sample_period, r.period);
  endtask

  initial
  begin
    int i;
    speed_reset_event = 1'b1;
    key_ascii         = '0;
    key_valid         = 1'b0;
    speed_up_event    = 1'b0;
    speed_down_event  = 1'b0;
    model_addr        = '0;
    model_second      = 1'b0;
    model_forward     = 1'b1;
    sample_count      = 0;
    repeat (5) @(posedge CLK_50M);
    speed_reset_event <= 1'b0;
    for (i = 0; i < n_rows; i++)
      apply_row(stim[i]);
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: verif/tb_flash_model.sv
`timescale 1ns/1ps

module tb_flash_model (
  input  logic                   CLK_50M,
  input  logic                   speed_reset_event,
  input  logic                   flash_read,
  input  audio_pkg::flash_addr_t flash_address,
  output logic                   flash_waitrequest,
  output audio_pkg::flash_data_t flash_readdata,
  output logic                   flash_readdatavalid
);

  import audio_pkg::*;

  logic [15:0] lfsr_q;
  logic [1:0]  wait_left;
  logic [3:0]  latency_left;
  logic        pending;
  flash_data_t pending_word;

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    else
      return s >> 1;
  endfunction

  // Five bits, one LFSR step each, new state returned above them
  function automatic logic [20:0] draw_bits(input logic [15:0] seed);
    logic [15:0] s;
    logic [4:0]  bits;
    int          i;
    s = seed;
    for (i = 0; i < 5; i++)
    begin
      s = lfsr_next(s);
      bits[i] = s[0];
    end
    return {s, bits};
  endfunction

  // Byte 3 is a*16+1, byte 1 is a*16+2
  function automatic flash_data_t word_at(input flash_addr_t a);
    return {a[3:0], 4'h1, 8'hFF, a[3:0], 4'h2, 8'hFF};
  endfunction

  assign flash_waitrequest = (wait_left != 2'd0);

  always @(posedge CLK_50M)
  begin : flash_seq
    logic [20:0] draw;
    if (speed_reset_event)
    begin
      draw                = draw_bits(16'd35);
      lfsr_q              <= draw[20:5];
      wait_left           <= draw[4:3];
      pending             <= 1'b0;
      latency_left        <= 4'd0;
      flash_readdatavalid <= 1'b0;
      flash_readdata      <= '0;
    end
    else
    begin
      flash_readdatavalid <= 1'b0;
      if (flash_read && flash_waitrequest)
        wait_left <= wait_left - 2'd1;
      else if (flash_read && !pending)
      begin
        // Request taken, draw its latency and the next wait length
        draw         = draw_bits(lfsr_q);
        lfsr_q       <= draw[20:5];
        latency_left <= {1'b0, draw[2:0]} + 4'd1;
        wait_left    <= draw[4:3];
        pending_word <= word_at(flash_address);
        pending      <= 1'b1;
      end
      if (pending)
      begin
        if (latency_left == 4'd1)
        begin
          flash_readdatavalid <= 1'b1;
          flash_readdata      <= pending_word;
          pending             <= 1'b0;
        end
        else
          latency_left <= latency_left - 4'd1;
      end
    end
  end

endmodule

// File: hw/audio_player_top.sv
`timescale 1ns/1ps

module audio_player_top #(
  parameter audio_pkg::period_t     default_period = 16'd2272,
  parameter audio_pkg::period_t     min_period     = 16'd32,
  parameter audio_pkg::flash_addr_t last_word_addr = 23'h7FFFF
) (
  input  logic                   CLK_50M,
  input  logic                   speed_reset_event,
  input  audio_pkg::sample_t     key_ascii,
  input  logic                   key_valid,
  input  logic                   speed_up_event,
  input  logic                   speed_down_event,
  input  logic                   flash_waitrequest,
  input  audio_pkg::flash_data_t flash_readdata,
  input  logic                   flash_readdatavalid,
  output logic                   flash_read,
  output audio_pkg::flash_addr_t flash_address,
  output audio_pkg::sample_t     sample_out,
  output logic                   sample_valid,
  output audio_pkg::period_t     sample_period
);

  // Player controls from the keyboard
  logic playing;
  logic forward;
  logic restart;

  // Playback handshakes
  logic sample_tick;
  logic addr_step;
  logic capture_word;
  logic present_sample;
  logic use_low_half;

  key_command_decoder u_key_command_decoder (
    .CLK_50M           (CLK_50M),
    .speed_reset_event (speed_reset_event),
    .key_ascii         (key_ascii),
    .key_valid         (key_valid),
    .playing           (playing),
    .forward           (forward),
    .restart           (restart)
  );

  sample_rate_gen #(
    .default_period (default_period),
    .min_period     (min_period)
  ) u_sample_rate_gen (
    .CLK_50M           (CLK_50M),
    .speed_reset_event (speed_reset_event),
    .speed_up_event    (speed_up_event),
    .speed_down_event  (speed_down_event),
    .sample_tick       (sample_tick),
    .sample_period     (sample_period)
  );

  song_address_counter #(
    .last_word_addr (last_word_addr)
  ) u_song_address_counter (
    .CLK_50M           (CLK_50M),
    .speed_reset_event (speed_reset_event),
    .forward           (forward),
    .restart           (restart),
    .addr_step         (addr_step),
    .flash_address     (flash_address)
  );

  flash_read_sequencer u_flash_read_sequencer (
    .CLK_50M             (CLK_50M),
    .speed_reset_event   (speed_reset_event),
    .playing             (playing),
    .forward             (forward),
    .restart             (restart),
    .sample_tick         (sample_tick),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .addr_step           (addr_step),
    .capture_word        (capture_word),
    .present_sample      (present_sample),
    .use_low_half        (use_low_half)
  );

  sample_byte_latch u_sample_byte_latch (
    .CLK_50M           (CLK_50M),
    .speed_reset_event (speed_reset_event),
    .flash_readdata    (flash_readdata),
    .capture_word      (capture_word),
    .present_sample    (present_sample),
    .use_low_half      (use_low_half),
    .sample_out        (sample_out),
    .sample_valid      (sample_valid)
  );

endmodule

// File: playback/sample_byte_latch.sv
`timescale 1ns/1ps

module sample_byte_latch (
  input  logic                   CLK_50M,
  input  logic                   speed_reset_event,
  input  audio_pkg::flash_data_t flash_readdata,
  input  logic                   capture_word,
  input  logic                   present_sample,
  input  logic                   use_low_half,
  output audio_pkg::sample_t     sample_out,
  output logic                   sample_valid
);

  import audio_pkg::*;

  flash_data_t word_q;

  // Word from the last completed read
  always_ff @(posedge CLK_50M)
  begin
    if (capture_word)
      word_q <= flash_readdata;
  end

  // Samples sit in bits 31:24 and 15:8
  always_ff @(posedge CLK_50M)
  begin
    if (present_sample)
      sample_out <= use_low_half ? word_q[15:8] : word_q[31:24];
  end

  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
      sample_valid <= 1'b0;
    else
      sample_valid <= present_sample;
  end

endmodule

// File: playback/flash_read_sequencer.sv
`timescale 1ns/1ps

module flash_read_sequencer (
  input  logic CLK_50M,
  input  logic speed_reset_event,
  input  logic playing,
  input  logic forward,
  input  logic restart,
  input  logic sample_tick,
  input  logic flash_waitrequest,
  input  logic flash_readdatavalid,
  output logic flash_read,
  output logic addr_step,
  output logic capture_word,
  output logic present_sample,
  output logic use_low_half
);

  import audio_pkg::*;

  read_state_t state;
  read_state_t state_next;

  // Set when a restart lands on a read in flight
  logic drop_word;

  logic second_due;

  // ====================
  // State register
  // ====================
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      state     <= idle;
      drop_word <= 1'b0;
    end
    else
    begin
      state <= state_next;
      if ((state == wait_data) && flash_readdatavalid)
        drop_word <= 1'b0;
      else if (restart && ((state == request) || (state == wait_data)))
        drop_word <= 1'b1;
    end
  end

  // ====================
  // Next state
  // ====================
  always_comb
  begin
    state_next = state;
    case (state)
      idle:
        if (playing && sample_tick && !restart)
          state_next = request;
      // Read must stay up until the flash takes it
      request:
        if (!flash_waitrequest)
          state_next = wait_data;
      wait_data:
        if (flash_readdatavalid)
          state_next = (drop_word || restart) ? idle : first_sample;
      // A paused player holds the fetched sample here
      first_sample:
        if (restart)
          state_next = idle;
        else if (playing)
          state_next = second_wait;
      second_wait:
        if (restart || (playing && sample_tick))
          state_next = idle;
      default:
        state_next = idle;
    endcase
  end

  // ====================
  // Outputs
  // ====================
  assign second_due = (state == second_wait) && playing && sample_tick && !restart;

  assign flash_read     = (state == request);
  assign capture_word   = (state == wait_data) && flash_readdatavalid && !drop_word && !restart;
  assign present_sample = ((state == first_sample) && playing && !restart) || second_due;
  assign addr_step      = second_due;

  // Forward plays the high byte first, backward the low byte first
  assign use_low_half = (state == first_sample) ? !forward : forward;

endmodule

// File: playback/song_address_counter.sv
`timescale 1ns/1ps

module song_address_counter #(
  parameter audio_pkg::flash_addr_t last_word_addr = 23'h7FFFF
) (
  input  logic                   CLK_50M,
  input  logic                   speed_reset_event,
  input  logic                   forward,
  input  logic                   restart,
  input  logic                   addr_step,
  output audio_pkg::flash_addr_t flash_address
);

  // Restart wins over a step in the same cycle
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      flash_address <= '0;
    end
    else if (restart)
    begin
      // Start of the song for the chosen direction
      flash_address <= forward ? '0 : last_word_addr;
    end
    else if (addr_step)
    begin
      if (forward)
      begin
        if (flash_address == last_word_addr)
          flash_address <= '0;
        else
          flash_address <= flash_address + 1'b1;
      end
      else
      begin
        if (flash_address == '0)
          flash_address <= last_word_addr;
        else
          flash_address <= flash_address - 1'b1;
      end
    end
  end

endmodule

// File: hw/sample_rate_gen.sv
`timescale 1ns/1ps

module sample_rate_gen #(
  parameter audio_pkg::period_t default_period = 16'd2272,
  parameter audio_pkg::period_t min_period     = 16'd32
) (
  input  logic               CLK_50M,
  input  logic               speed_reset_event,
  input  logic               speed_up_event,
  input  logic               speed_down_event,
  output logic               sample_tick,
  output audio_pkg::period_t sample_period
);

  import audio_pkg::*;

  period_t cycle_count;

  // ====================
  // Period register
  // ====================
  // Speed up shortens the period, speed down lengthens it
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      sample_period <= default_period;
    end
    else if (speed_up_event)
    begin
      if (sample_period > min_period)
      begin
        sample_period <= sample_period - 1'b1;
      end
    end
    else if (speed_down_event)
    begin
      // Saturate at the top of the counter range
      if (sample_period != {period_width{1'b1}})
      begin
        sample_period <= sample_period + 1'b1;
      end
    end
  end

  // ====================
  // Tick counter
  // ====================
  // Counts down and reloads from the current period
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      cycle_count <= default_period - 1'b1;
      sample_tick <= 1'b0;
    end
    else if (cycle_count == '0)
    begin
      cycle_count <= sample_period - 1'b1;
      sample_tick <= 1'b1;
    end
    else
    begin
      cycle_count <= cycle_count - 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

// File: hw/key_command_decoder.sv
`timescale 1ns/1ps

module key_command_decoder (
  input  logic               CLK_50M,
  input  logic               speed_reset_event,
  input  audio_pkg::sample_t key_ascii,
  input  logic               key_valid,
  output logic               playing,
  output logic               forward,
  output logic               restart
);

  import audio_pkg::*;

  key_cmd_t key_cmd;

  assign key_cmd = key_cmd_t'(key_ascii);

  // Play and direction flags, restart as a single pulse
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      playing <= 1'b0;
      forward <= 1'b1;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (key_valid)
      begin
        case (key_cmd)
          cmd_play:     playing <= 1'b1;
          cmd_pause:    playing <= 1'b0;
          cmd_forward:  forward <= 1'b1;
          cmd_backward: forward <= 1'b0;
          cmd_restart:  restart <= 1'b1;
          // Any other key is ignored
          default:      ;
        endcase
      end
    end
  end

endmodule

// File: common/audio_pkg.sv
package audio_pkg;

  // ====================
  // Widths
  // ====================
  localparam int flash_addr_width = 23;
  localparam int flash_data_width = 32;
  localparam int sample_width     = 8;
  localparam int period_width     = 16;

  typedef logic [flash_addr_width-1:0] flash_addr_t;
  typedef logic [flash_data_width-1:0] flash_data_t;
  typedef logic [sample_width-1:0]     sample_t;
  typedef logic [period_width-1:0]     period_t;

  // ====================
  // Keyboard commands
  // ====================
  // Values are the ASCII codes of the upper case keys
  typedef enum logic [7:0] {
    cmd_backward = 8'h42,
    cmd_pause    = 8'h44,
    cmd_play     = 8'h45,
    cmd_forward  = 8'h46,
    cmd_restart  = 8'h52
  } key_cmd_t;

  // ====================
  // Flash read sequencer
  // ====================
  typedef enum logic [2:0] {
    idle,
    request,
    wait_data,
    first_sample,
    second_wait
  } read_state_t;

endpackage
